/* lvds_pkg.sv */
`default_nettype none

package lvds_pkg;

  localparam int NUM_GROUPS = 4;
  localparam int GROUP_W = $clog2(NUM_GROUPS);

  // 31-bit cell control word, select bits at the top and power-on reset in bit 0.
  typedef logic [30:0] ctrl_word_t;

  localparam int DRV_A_LSB = 17;  // drive strength of the A cell.
  localparam int DRV_B_LSB = 15;  // drive strength of the B cell.
  localparam int DRV_W = 2;
  localparam int POR_BIT = 0;
  localparam int POR_CYCLES = 16;  // cycles the cell reset stays high.
  localparam int POR_W = $clog2(POR_CYCLES);

  // Rx and tx selected, bias powered, current set 01 on both cells.
  localparam ctrl_word_t CTRL_BASE = {4'b1111, 2'b00, 4'b0101, 21'd0};

  typedef logic [1:0] lane_data_t;
  typedef logic [15:0] cnt_t;  // saturating counters.

  // x^7 + x^6 + 1.
  localparam int PRBS_TAP_A = 7;
  localparam int PRBS_TAP_B = 6;
  typedef logic [PRBS_TAP_A-1:0] prbs_t;

  localparam int FILL_CYCLES = 4;  // received cycles before the checker compares.
  localparam int FILL_W = $clog2(FILL_CYCLES + 1);

endpackage

`default_nettype wire

/* panel_pkg.sv */
`default_nettype none

package panel_pkg;

  typedef logic [7:0] mode_t;

  localparam int NUM_DIGITS = 4;
  localparam int DIGIT_W = $clog2(NUM_DIGITS);
  localparam int NIBBLE_W = 4;

  typedef logic [NUM_DIGITS-1:0] digit_sel_t;  // one-hot, active high.
  typedef logic [NIBBLE_W-1:0] nibble_t;

  // Segments g..a in bits 6..0, decimal point in bit 7.
  typedef logic [7:0] seg_t;

  localparam int NUM_BUTTONS = 3;
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int DEBOUNCE_W = $clog2(DEBOUNCE_CYCLES);

  localparam int SCAN_CYCLES = 8;  // cycles each digit stays lit.
  localparam int SCAN_W = $clog2(SCAN_CYCLES);

  typedef enum logic [1:0] {
    IDLE,
    PRESS,
    HELD
  } state_t;

endpackage

`default_nettype wire

/* test_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module test_ctrl
  import lvds_pkg::*, panel_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire        btn_1,
  input  wire        btn_2,
  input  wire        btn_3,
  output mode_t      main_mode,
  output mode_t      sub_mode,
  output logic       clear,
  output ctrl_word_t ctrl [NUM_GROUPS]
);

  logic [NUM_BUTTONS-1:0] btn_raw;
  logic [NUM_BUTTONS-1:0] press;
  logic                   por;
  logic [POR_W-1:0]       por_cnt;
  ctrl_word_t             word_next;

  assign btn_raw = {btn_3, btn_2, btn_1};

  // a press must hold steady for DEBOUNCE_CYCLES before it strobes once.
  for (genvar i = 0; i < NUM_BUTTONS; i++) begin : g_debounce
    logic                  btn_q;
    logic                  strobe;
    state_t                state;
    logic [DEBOUNCE_W-1:0] cnt;

    always_ff @(posedge clk) begin
      if (reset) begin
        btn_q  <= 1'b0;
        strobe <= 1'b0;
        state  <= IDLE;
        cnt    <= '0;
      end else begin
        btn_q  <= btn_raw[i];
        strobe <= 1'b0;
        case (state)
          IDLE: begin
            cnt <= '0;
            if (btn_q) state <= PRESS;
          end
          PRESS: begin
            if (!btn_q) begin
              state <= IDLE;  // a bounce starts over.
            end else if (cnt == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1)) begin
              state  <= HELD;
              strobe <= 1'b1;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
          HELD: begin
            if (!btn_q) state <= IDLE;
          end
          default: state <= IDLE;
        endcase
      end
    end

    assign press[i] = strobe;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      main_mode <= '0;
      sub_mode  <= '0;
      clear     <= 1'b0;
    end else begin
      clear <= press[2];
      if (press[0]) main_mode <= main_mode + 1'b1;  // wraps at 256.
      if (press[1]) sub_mode <= sub_mode + 1'b1;
    end
  end

  // The cell reset is held for POR_CYCLES after reset and after each clear.
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      por     <= 1'b1;
      por_cnt <= '0;
    end else if (por) begin
      por_cnt <= por_cnt + 1'b1;
      if (por_cnt == POR_W'(POR_CYCLES - 1)) por <= 1'b0;
    end
  end

  always_comb begin
    word_next                          = CTRL_BASE;
    word_next[DRV_A_LSB +: DRV_W]      = sub_mode[DRV_W-1:0];
    word_next[DRV_B_LSB +: DRV_W]      = sub_mode[DRV_W-1:0];
    word_next[POR_BIT]                 = por;
  end

  // all groups get the same word.
  always_ff @(posedge clk) begin
    for (int g = 0; g < NUM_GROUPS; g++) begin
      ctrl[g] <= word_next;
    end
  end

endmodule

`default_nettype wire

/* lane_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_checker
  import lvds_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire        clear,
  input  wire        lane_data_t din,
  output lane_data_t dout,
  output cnt_t       recv_cnt,
  output cnt_t       err_cnt
);

  // Next two bits from the last seven, newest bit in position 0.
  function automatic lane_data_t predict(input prbs_t hist);
    logic first;
    logic second;
    first  = hist[PRBS_TAP_A-1] ^ hist[PRBS_TAP_B-1];
    second = hist[PRBS_TAP_A-2] ^ hist[PRBS_TAP_B-2];
    return {first, second};
  endfunction

  prbs_t                  tx_hist;
  lane_data_t             tx_pair;
  lane_data_t             din_meta;
  lane_data_t             din_sync;
  prbs_t                  rx_hist;
  lane_data_t             expect_pair;
  lane_data_t             diff;
  logic [1:0]             miss;
  logic [FILL_W-1:0]      fill_cnt;
  logic                   check_en;
  logic [$bits(cnt_t):0]  err_sum;

  assign tx_pair = predict(tx_hist);

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_hist <= '1;  // seed.
      dout    <= '0;
    end else begin
      tx_hist <= {tx_hist[PRBS_TAP_A-3:0], tx_pair};
      dout    <= tx_pair;
    end
  end

  // the receive history is built from what came back, so any loop delay works.
  always_ff @(posedge clk) begin
    if (reset) begin
      din_meta <= '0;
      din_sync <= '0;
      rx_hist  <= '0;
    end else begin
      din_meta <= din;
      din_sync <= din_meta;
      rx_hist  <= {rx_hist[PRBS_TAP_A-3:0], din_sync};
    end
  end

  assign expect_pair = predict(rx_hist);
  assign diff        = expect_pair ^ din_sync;
  assign miss        = {1'b0, diff[1]} + {1'b0, diff[0]};
  assign check_en    = (fill_cnt == FILL_W'(FILL_CYCLES));
  assign err_sum     = {1'b0, err_cnt} + {{($bits(cnt_t) - 1){1'b0}}, miss};

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      fill_cnt <= '0;
      recv_cnt <= '0;
      err_cnt  <= '0;
    end else begin
      // An all-zero history means the sequence has not arrived yet.
      if (!check_en && rx_hist != '0) fill_cnt <= fill_cnt + 1'b1;
      if (recv_cnt != '1) recv_cnt <= recv_cnt + 1'b1;
      if (check_en) begin
        err_cnt <= err_sum[$bits(cnt_t)] ? '1 : err_sum[$bits(cnt_t)-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* handle_7seg.sv */
`timescale 1ns/100ps
`default_nettype none

module handle_7seg
  import lvds_pkg::*, panel_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire mode_t main_mode,
  input  wire cnt_t  recv_cnt [NUM_GROUPS],
  input  wire cnt_t  err_cnt [NUM_GROUPS],
  output digit_sel_t digit_sel,
  output seg_t       digit
);

  function automatic seg_t hex_to_seg(input nibble_t value);
    seg_t seg;
    case (value)
      4'h0:    seg = 8'h3f;
      4'h1:    seg = 8'h06;
      4'h2:    seg = 8'h5b;
      4'h3:    seg = 8'h4f;
      4'h4:    seg = 8'h66;
      4'h5:    seg = 8'h6d;
      4'h6:    seg = 8'h7d;
      4'h7:    seg = 8'h07;
      4'h8:    seg = 8'h7f;
      4'h9:    seg = 8'h6f;
      4'ha:    seg = 8'h77;
      4'hb:    seg = 8'h7c;
      4'hc:    seg = 8'h39;
      4'hd:    seg = 8'h5e;
      4'he:    seg = 8'h79;
      default: seg = 8'h71;
    endcase
    return seg;
  endfunction

  logic [GROUP_W-1:0] group;
  cnt_t               shown;
  nibble_t            nibble;
  logic [SCAN_W-1:0]  scan_cnt;
  logic [DIGIT_W-1:0] digit_idx;

  // Low mode bits pick the group, the next bit picks errors over words.
  assign group  = main_mode[GROUP_W-1:0];
  assign shown  = main_mode[GROUP_W] ? err_cnt[group] : recv_cnt[group];
  assign nibble = shown[NIBBLE_W*digit_idx +: NIBBLE_W];

  // select and segments load together, so they always belong to one digit.
  always_ff @(posedge clk) begin
    if (reset) begin
      scan_cnt  <= '0;
      digit_idx <= '0;
      digit_sel <= '0;  // dark until the first scan tick.
      digit     <= '0;
    end else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1)) begin
      scan_cnt  <= '0;
      digit_idx <= digit_idx + 1'b1;
      digit_sel <= digit_sel_t'(1) << digit_idx;
      digit     <= hex_to_seg(nibble);
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* lvds_test.sv */
`timescale 1ns/100ps
`default_nettype none

module lvds_test
  import lvds_pkg::*, panel_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire        btn_1,
  input  wire        btn_2,
  input  wire        btn_3,
  input  wire        lane_data_t nt_din,
  input  wire        lane_data_t et_din,
  input  wire        lane_data_t st_din,
  input  wire        lane_data_t sc_din,
  output lane_data_t nt_dout,
  output lane_data_t et_dout,
  output lane_data_t st_dout,
  output lane_data_t sc_dout,
  output ctrl_word_t nt_ctrl,
  output ctrl_word_t et_ctrl,
  output ctrl_word_t st_ctrl,
  output ctrl_word_t sc_ctrl,
  output digit_sel_t digit_sel,
  output seg_t       digit
);

  mode_t      main_mode;
  logic       clear;
  ctrl_word_t ctrl [NUM_GROUPS];
  lane_data_t din [NUM_GROUPS];
  lane_data_t dout [NUM_GROUPS];
  cnt_t       recv_cnt [NUM_GROUPS];
  cnt_t       err_cnt [NUM_GROUPS];

  test_ctrl test_ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .btn_1     (btn_1),
    .btn_2     (btn_2),
    .btn_3     (btn_3),
    .main_mode (main_mode),
    .sub_mode  (),
    .clear     (clear),
    .ctrl      (ctrl)
  );

  // group order on the loop index is NT, ET, ST, SC.
  assign din[0]  = nt_din;
  assign din[1]  = et_din;
  assign din[2]  = st_din;
  assign din[3]  = sc_din;
  assign nt_dout = dout[0];
  assign et_dout = dout[1];
  assign st_dout = dout[2];
  assign sc_dout = dout[3];
  assign nt_ctrl = ctrl[0];
  assign et_ctrl = ctrl[1];
  assign st_ctrl = ctrl[2];
  assign sc_ctrl = ctrl[3];

  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_lane
    lane_checker lane_checker_i (
      .clk      (clk),
      .reset    (reset),
      .clear    (clear),
      .din      (din[g]),
      .dout     (dout[g]),
      .recv_cnt (recv_cnt[g]),
      .err_cnt  (err_cnt[g])
    );
  end

  handle_7seg handle_7seg_i (
    .clk       (clk),
    .reset     (reset),
    .main_mode (main_mode),
    .recv_cnt  (recv_cnt),
    .err_cnt   (err_cnt),
    .digit_sel (digit_sel),
    .digit     (digit)
  );

endmodule

`default_nettype wire

/* lvds_test_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module lvds_test_properties
  import lvds_pkg::*, panel_pkg::*;
(
  input wire             clk,
  input wire             reset,
  input wire lane_data_t nt_dout,
  input wire lane_data_t et_dout,
  input wire lane_data_t st_dout,
  input wire lane_data_t sc_dout,
  input wire ctrl_word_t nt_ctrl,
  input wire ctrl_word_t et_ctrl,
  input wire ctrl_word_t st_ctrl,
  input wire ctrl_word_t sc_ctrl,
  input wire digit_sel_t digit_sel,
  input wire seg_t       digit
);

  logic dout_quiet;
  logic por_high;

  assign dout_quiet = (nt_dout == '0) && (et_dout == '0) && (st_dout == '0) && (sc_dout == '0);
  assign por_high   = nt_ctrl[POR_BIT] && et_ctrl[POR_BIT] && st_ctrl[POR_BIT] && sc_ctrl[POR_BIT];

  a_sel_onehot: assert property (@(posedge clk) $onehot0(digit_sel))
    else $error("more than one digit is selected");

  a_dp_off: assert property (@(posedge clk) digit[7] == 1'b0)
    else $error("decimal point is lit");

  // each reset cycle loads a zero into the data outputs.
  a_dout_reset: assert property (@(posedge clk) reset |=> dout_quiet)
    else $error("data output is not zero during reset");

  a_por_after_reset: assert property (@(posedge clk) $fell(reset) |-> por_high)
    else $error("cell power-on reset is low right after reset");

endmodule

bind lvds_test lvds_test_properties lvds_test_properties_i (
  .clk       (clk),
  .reset     (reset),
  .nt_dout   (nt_dout),
  .et_dout   (et_dout),
  .st_dout   (st_dout),
  .sc_dout   (sc_dout),
  .nt_ctrl   (nt_ctrl),
  .et_ctrl   (et_ctrl),
  .st_ctrl   (st_ctrl),
  .sc_ctrl   (sc_ctrl),
  .digit_sel (digit_sel),
  .digit     (digit)
);

`default_nettype wire

/* tb_lvds_test.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lvds_test
  import lvds_pkg::*, panel_pkg::*;
();

  localparam int LONG_PRESS  = DEBOUNCE_CYCLES + 8;
  localparam int SHORT_PRESS = DEBOUNCE_CYCLES / 2;
  localparam int WAIT_LIMIT  = 6 * SCAN_CYCLES;

  logic       clk;
  logic       reset;
  logic       btn [NUM_BUTTONS];
  lane_data_t din [NUM_GROUPS] = '{default: '0};
  lane_data_t dout [NUM_GROUPS];
  lane_data_t flip [NUM_GROUPS];
  ctrl_word_t ctrl [NUM_GROUPS];
  digit_sel_t digit_sel;
  seg_t       digit;
  integer     seed = 32'h76f38d27;
  mode_t      main_model;
  mode_t      sub_model;
  cnt_t       err_model [NUM_GROUPS];
  logic       passed = 1'b0;
  logic       failed = 1'b0;

  lvds_test lvds_test_i (
    .clk       (clk),
    .reset     (reset),
    .btn_1     (btn[0]),
    .btn_2     (btn[1]),
    .btn_3     (btn[2]),
    .nt_din    (din[0]),
    .et_din    (din[1]),
    .st_din    (din[2]),
    .sc_din    (din[3]),
    .nt_dout   (dout[0]),
    .et_dout   (dout[1]),
    .st_dout   (dout[2]),
    .sc_dout   (dout[3]),
    .nt_ctrl   (ctrl[0]),
    .et_ctrl   (ctrl[1]),
    .st_ctrl   (ctrl[2]),
    .sc_ctrl   (ctrl[3]),
    .digit_sel (digit_sel),
    .digit     (digit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // the loopback register inverts the bits set in flip for one cycle.
  always @(posedge clk) begin
    for (int g = 0; g < NUM_GROUPS; g++) begin
      din[g] <= dout[g] ^ flip[g];
    end
  end

  function automatic void print_fail();
    $display("Verification failed");
  endfunction

  task automatic fail_run(input string line);
    failed = 1'b1;
    $display("%s", line);
    print_fail();
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic value_error(input string msg);
    fail_run($sformatf("[ERROR] %0t: %s", $time, msg));
  endtask

  function automatic seg_t seg_code(input nibble_t value);
    case (value)
      4'h0: return 8'h3f;
      4'h1: return 8'h06;
      4'h2: return 8'h5b;
      4'h3: return 8'h4f;
      4'h4: return 8'h66;
      4'h5: return 8'h6d;
      4'h6: return 8'h7d;
      4'h7: return 8'h07;
      4'h8: return 8'h7f;
      4'h9: return 8'h6f;
      4'ha: return 8'h77;
      4'hb: return 8'h7c;
      4'hc: return 8'h39;
      4'hd: return 8'h5e;
      4'he: return 8'h79;
      default: return 8'h71;
    endcase
  endfunction

  function automatic int seg_to_nibble(input seg_t seg);
    int found;
    found = -1;  // no hex digit has this pattern.
    for (int n = 0; n < 16; n++) begin
      if (seg_code(nibble_t'(n)) == seg) found = n;
    end
    return found;
  endfunction

  task automatic wait_sel(input digit_sel_t want);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) fail_run($sformatf("timeout waiting for digit_sel %b", want));
    end while (digit_sel !== want);
  endtask

  // Reads one full scan round from digit 0 and decodes it back to a counter value.
  task automatic read_round(output cnt_t value);
    int nib;
    wait_sel(digit_sel_t'(1) << (NUM_DIGITS - 1));
    for (int k = 0; k < NUM_DIGITS; k++) begin
      wait_sel(digit_sel_t'(1) << k);
      nib = seg_to_nibble(digit);
      assert (nib >= 0)
        else value_error($sformatf("digit_sel %b shows unknown segments %h", digit_sel, digit));
      value[NIBBLE_W*k +: NIBBLE_W] = nibble_t'(nib);
    end
  endtask

  task automatic check_shown(input cnt_t expected);
    cnt_t value;
    read_round(value);
    assert (value == expected)
      else value_error($sformatf("mode %0d shows %h, expected %h", main_model, value, expected));
  endtask

  task automatic press_button(input int idx, input int hold);
    @(posedge clk);
    btn[idx] <= 1'b1;
    repeat (hold) @(posedge clk);
    btn[idx] <= 1'b0;
    repeat (4) @(posedge clk);
    if (hold > DEBOUNCE_CYCLES + 2) begin
      if (idx == 0) main_model = main_model + 1'b1;
      if (idx == 1) sub_model = sub_model + 1'b1;
    end
  endtask

  task automatic select_mode(input mode_t target);
    while (main_model != target) press_button(0, LONG_PRESS);
  endtask

  task automatic inject_flip(input int g);
    int         gap;
    lane_data_t mask;
    gap  = 10 + ($random(seed) & 15);
    mask = (($random(seed) & 1) != 0) ? 2'b10 : 2'b01;
    repeat (gap) @(posedge clk);
    flip[g] <= mask;
    @(posedge clk);
    flip[g] <= '0;
    err_model[g] = err_model[g] + 16'd3;  // the bit and the two predictions that use it.
  endtask

  task automatic check_ctrl();
    ctrl_word_t want;
    want        = CTRL_BASE;
    want[18:17] = sub_model[1:0];
    want[16:15] = sub_model[1:0];
    want[0]     = 1'b0;
    @(negedge clk);
    for (int g = 0; g < NUM_GROUPS; g++) begin
      assert (ctrl[g] === want)
        else value_error($sformatf("group %0d control %h, expected %h", g, ctrl[g], want));
    end
  endtask

  task automatic wait_por(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 3 * POR_CYCLES) fail_run("timeout waiting for the cell power-on reset to change");
      for (int g = 1; g < NUM_GROUPS; g++) begin
        assert (ctrl[g][POR_BIT] === ctrl[0][POR_BIT])
          else value_error($sformatf("group %0d power-on reset differs from group 0", g));
      end
    end while (ctrl[0][POR_BIT] !== level);
  endtask

  task automatic press_clear();
    int n;
    @(posedge clk);
    btn[2] <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 3 * DEBOUNCE_CYCLES) fail_run("timeout waiting for the clear pulse");
    end while (lvds_test_i.clear !== 1'b1);
    @(negedge clk);  // counters are zero one cycle after the pulse.
    for (int g = 0; g < NUM_GROUPS; g++) begin
      assert (lvds_test_i.recv_cnt[g] == '0 && lvds_test_i.err_cnt[g] == '0)
        else value_error($sformatf("group %0d counters not cleared", g));
      err_model[g] = '0;
    end
    wait_por(1'b1);
    wait_por(1'b0);
    @(posedge clk);
    btn[2] <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  initial begin
    cnt_t first;
    cnt_t second;
    int   flips [NUM_GROUPS];
    flips = '{1, 2, 0, 3};
    reset = 1'b1;
    main_model = '0;
    sub_model  = '0;
    for (int i = 0; i < NUM_BUTTONS; i++) begin
      btn[i] = 1'b0;
    end
    for (int g = 0; g < NUM_GROUPS; g++) begin
      flip[g]      = '0;
      err_model[g] = '0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    // The group 0 word count is still below 0x100, so its nibbles move forward together.
    read_round(first);
    read_round(second);
    assert (second > first)
      else value_error($sformatf("word count went from %h to %h", first, second));
    for (int g = 0; g < NUM_GROUPS; g++) begin
      select_mode(mode_t'(4 + g));
      check_shown('0);
    end
    for (int g = 0; g < NUM_GROUPS; g++) begin
      for (int i = 0; i < flips[g]; i++) begin
        inject_flip(g);
      end
    end
    repeat (8) @(posedge clk);
    check_shown(err_model[3]);
    for (int g = 0; g < 3; g++) begin
      select_mode(mode_t'(12 + g));
      check_shown(err_model[g]);
    end
    press_button(0, SHORT_PRESS);  // too short, so group 2 stays selected.
    check_shown(err_model[2]);
    press_button(0, LONG_PRESS);
    check_shown(err_model[3]);
    check_ctrl();
    repeat (5) begin
      press_button(1, LONG_PRESS);
      check_ctrl();
    end
    press_clear();
    check_shown(err_model[3]);
    passed = 1'b1;
    $display("Verification passed");
    $finish;
  end

  final begin
    if (!passed && !failed) print_fail();
  end

endmodule

`default_nettype wire

/* lvds_test.f */
lvds_pkg.sv
panel_pkg.sv
test_ctrl.sv
lane_checker.sv
handle_7seg.sv
lvds_test.sv
lvds_test_properties.sv
tb_lvds_test.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lvds_test --Mdir "$build_dir" -o sim_lvds_test \
  -f lvds_test.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/sim_lvds_test" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification passed" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1
